// File: src/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// half-precision word layout
`define FPU_HALF_W 16
`define FPU_EXP_W 5
`define FPU_FRAC_W 10

// one bit per FCLASS category
`define FPU_CLASS_W 10

// queue entries, also the credits the upstream starts with
`define FPU_REQ_DEPTH 4

// credits held toward the downstream after reset
`define FPU_RSP_CREDITS 2

// canonical quiet NaN
`define FPU_CANON_NAN 16'h7e00

`endif

// File: src/fpu_types_pkg.sv
`include "fpu_config.svh"

package fpu_types_pkg;

	// operations accepted on the request port
	typedef enum logic [2:0]
	{
		OP_FEQ = 3'd0,
		OP_FLT = 3'd1,
		OP_FLE = 3'd2,
		OP_FMIN = 3'd3,
		OP_FMAX = 3'd4,
		OP_FCLASS = 3'd5
	} fpu_op_t;

	// compare sub-operation, rm field encoding of the compare instructions
	typedef enum logic [2:0]
	{
		RM_FLE = 3'b000,
		RM_FLT = 3'b001,
		RM_FEQ = 3'b010
	} fpu_cmp_rm_t;

	typedef struct packed
	{
		logic sign;
		logic [`FPU_EXP_W - 1 : 0] exponent;
		logic [`FPU_FRAC_W - 1 : 0] fraction;
	} half_fields_t;

	// raw word or decoded fields of the same half float
	typedef union packed
	{
		logic [`FPU_HALF_W - 1 : 0] bits;
		half_fields_t fields;
	} half_word_u;

endpackage

// File: src/float_compare.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module float_compare
(
	input fpu_types_pkg::half_word_u float1,
	input fpu_types_pkg::half_word_u float2,

	// FEQ, FLT or FLE
	input fpu_types_pkg::fpu_cmp_rm_t operation,

	output logic out,
	output logic invalid
);

import fpu_types_pkg::*;

localparam logic [`FPU_EXP_W - 1 : 0] EXP_MAX = '1;

logic float1_nan, float2_nan;
logic float1_snan, float2_snan;
logic [`FPU_HALF_W - 2 : 0] float1_mag, float2_mag;
logic both_zero;
logic is_eq;
logic is_lt;

// exponent and fraction together order the magnitude
assign float1_mag = float1.bits[`FPU_HALF_W - 2 : 0];
assign float2_mag = float2.bits[`FPU_HALF_W - 2 : 0];

assign float1_nan = (float1.fields.exponent == EXP_MAX) && (float1.fields.fraction != '0);
assign float2_nan = (float2.fields.exponent == EXP_MAX) && (float2.fields.fraction != '0);
// signaling when the quiet bit is clear
assign float1_snan = float1_nan && !float1.fields.fraction[`FPU_FRAC_W - 1];
assign float2_snan = float2_nan && !float2.fields.fraction[`FPU_FRAC_W - 1];

// +0 and -0 are equal
assign both_zero = (float1_mag == '0) && (float2_mag == '0);
assign is_eq = (float1.bits == float2.bits) || both_zero;

always_comb
begin : ORDER
	if (both_zero)
		is_lt = 1'b0;
	else if (float1.fields.sign != float2.fields.sign)
		is_lt = float1.fields.sign;
	else if (float1.fields.sign)
		// negatives order the other way round
		is_lt = float1_mag > float2_mag;
	else
		is_lt = float1_mag < float2_mag;
end

always_comb
begin : OUTPUT
	out = 1'b0;
	invalid = 1'b0;
	case (operation)
		RM_FEQ:
		begin
			// quiet compare, only sNaN signals
			invalid = float1_snan || float2_snan;
			out = !(float1_nan || float2_nan) && is_eq;
		end
		RM_FLT:
		begin
			invalid = float1_nan || float2_nan;
			out = !(float1_nan || float2_nan) && is_lt;
		end
		RM_FLE:
		begin
			invalid = float1_nan || float2_nan;
			out = !(float1_nan || float2_nan) && (is_lt || is_eq);
		end
		default:
		begin
			out = 1'b0;
		end
	endcase
end

endmodule

// File: src/fp_minmax.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_minmax
(
	input fpu_types_pkg::half_word_u a,
	input fpu_types_pkg::half_word_u b,
	input logic take_max,

	output fpu_types_pkg::half_word_u result,
	output logic invalid
);

localparam logic [`FPU_EXP_W - 1 : 0] EXP_MAX = '1;

logic a_nan, b_nan;
logic a_snan, b_snan;
logic [`FPU_HALF_W - 2 : 0] a_mag, b_mag;
logic a_lt_b;

assign a_mag = a.bits[`FPU_HALF_W - 2 : 0];
assign b_mag = b.bits[`FPU_HALF_W - 2 : 0];

assign a_nan = (a.fields.exponent == EXP_MAX) && (a.fields.fraction != '0);
assign b_nan = (b.fields.exponent == EXP_MAX) && (b.fields.fraction != '0);
assign a_snan = a_nan && !a.fields.fraction[`FPU_FRAC_W - 1];
assign b_snan = b_nan && !b.fields.fraction[`FPU_FRAC_W - 1];

assign invalid = a_snan || b_snan;

// total order on non-NaN words, -0 below +0
always_comb
begin : ORDER
	if (a.fields.sign != b.fields.sign)
		a_lt_b = a.fields.sign;
	else if (a.fields.sign)
		a_lt_b = a_mag > b_mag;
	else
		a_lt_b = a_mag < b_mag;
end

always_comb
begin : SELECT
	if (a_nan && b_nan)
		result.bits = `FPU_CANON_NAN;
	else if (a_nan)
		// a single NaN yields the other operand
		result.bits = b.bits;
	else if (b_nan)
		result.bits = a.bits;
	else if (take_max)
		result.bits = a_lt_b ? b.bits : a.bits;
	else
		result.bits = a_lt_b ? a.bits : b.bits;
end

endmodule

// File: src/fp_classify.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_classify
(
	input fpu_types_pkg::half_word_u a,
	output logic [`FPU_CLASS_W - 1 : 0] mask
);

// bit positions of the RISC-V class mask
localparam int CLS_NEG_INF = 0;
localparam int CLS_NEG_NORM = 1;
localparam int CLS_NEG_SUB = 2;
localparam int CLS_NEG_ZERO = 3;
localparam int CLS_POS_ZERO = 4;
localparam int CLS_POS_SUB = 5;
localparam int CLS_POS_NORM = 6;
localparam int CLS_POS_INF = 7;
localparam int CLS_SNAN = 8;
localparam int CLS_QNAN = 9;

logic exp_max;
logic exp_zero;
logic frac_zero;
logic neg;

assign exp_max = (a.fields.exponent == '1);
assign exp_zero = (a.fields.exponent == '0);
assign frac_zero = (a.fields.fraction == '0);
assign neg = a.fields.sign;

always_comb
begin : CLASSIFY
	mask = '0;
	if (exp_max && !frac_zero)
	begin
		// NaN ignores the sign
		if (a.fields.fraction[`FPU_FRAC_W - 1])
			mask[CLS_QNAN] = 1'b1;
		else
			mask[CLS_SNAN] = 1'b1;
	end
	else if (exp_max)
		mask[neg ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
	else if (exp_zero && frac_zero)
		mask[neg ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
	else if (exp_zero)
		mask[neg ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
	else
		mask[neg ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
end

endmodule

// File: src/fpu_cmp_ctrl.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_cmp_ctrl
(
	input logic clk,
	input logic rst_n,

	// request side
	input logic req_valid,
	input fpu_types_pkg::fpu_op_t req_op,
	input logic [`FPU_HALF_W - 1 : 0] req_a,
	input logic [`FPU_HALF_W - 1 : 0] req_b,
	output logic req_credit,

	// response side
	output logic rsp_valid,
	output logic [`FPU_HALF_W - 1 : 0] rsp_result,
	output logic rsp_invalid,
	input logic rsp_credit,

	// toward the datapath
	output logic [`FPU_HALF_W - 1 : 0] head_a,
	output logic [`FPU_HALF_W - 1 : 0] head_b,
	output fpu_types_pkg::fpu_cmp_rm_t cmp_op,
	output logic take_max,

	// back from the datapath
	input logic cmp_out,
	input logic cmp_invalid,
	input logic [`FPU_HALF_W - 1 : 0] mm_result,
	input logic mm_invalid,
	input logic [`FPU_CLASS_W - 1 : 0] class_mask
);

import fpu_types_pkg::*;

localparam int DEPTH = `FPU_REQ_DEPTH;
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);
localparam int CRD_W = $clog2(`FPU_RSP_CREDITS + 1);

fpu_op_t op_q [DEPTH];
logic [`FPU_HALF_W - 1 : 0] a_q [DEPTH];
logic [`FPU_HALF_W - 1 : 0] b_q [DEPTH];

logic [PTR_W - 1 : 0] wr_ptr;
logic [PTR_W - 1 : 0] rd_ptr;
logic [CNT_W - 1 : 0] q_count;
logic [CRD_W - 1 : 0] rsp_credits;

fpu_op_t head_op;
logic issue;
logic [`FPU_HALF_W - 1 : 0] result_sel;
logic invalid_sel;

// circular increment, depth need not be a power of two
function automatic logic [PTR_W - 1 : 0] ptr_next(input logic [PTR_W - 1 : 0] ptr);
	if (ptr == PTR_W'(DEPTH - 1))
		return '0;
	return ptr + 1'b1;
endfunction

assign head_op = op_q[rd_ptr];
assign head_a = a_q[rd_ptr];
assign head_b = b_q[rd_ptr];

// issue needs a queued request and a downstream credit
assign issue = (q_count != '0) && (rsp_credits != '0);

always_ff @(posedge clk)
begin : QUEUE_MEM
	if (req_valid)
	begin
		op_q[wr_ptr] <= req_op;
		a_q[wr_ptr] <= req_a;
		b_q[wr_ptr] <= req_b;
	end
end

always_ff @(posedge clk or negedge rst_n)
begin : QUEUE_CTRL
	if (!rst_n)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		q_count <= '0;
	end
	else
	begin
		if (req_valid)
			wr_ptr <= ptr_next(wr_ptr);
		if (issue)
			rd_ptr <= ptr_next(rd_ptr);
		case ({req_valid, issue})
			2'b10: q_count <= q_count + 1'b1;
			2'b01: q_count <= q_count - 1'b1;
			default: q_count <= q_count;
		endcase
	end
end

// a credit back in the issue cycle nets out here
always_ff @(posedge clk or negedge rst_n)
begin : RSP_CREDITS
	if (!rst_n)
		rsp_credits <= CRD_W'(`FPU_RSP_CREDITS);
	else
	begin
		case ({rsp_credit, issue})
			2'b10: rsp_credits <= rsp_credits + 1'b1;
			2'b01: rsp_credits <= rsp_credits - 1'b1;
			default: rsp_credits <= rsp_credits;
		endcase
	end
end

always_comb
begin : DECODE
	cmp_op = RM_FEQ;
	take_max = 1'b0;
	case (head_op)
		OP_FEQ: cmp_op = RM_FEQ;
		OP_FLT: cmp_op = RM_FLT;
		OP_FLE: cmp_op = RM_FLE;
		OP_FMAX: take_max = 1'b1;
		default: take_max = 1'b0;
	endcase
end

always_comb
begin : RESULT_SELECT
	case (head_op)
		OP_FEQ, OP_FLT, OP_FLE:
		begin
			result_sel = `FPU_HALF_W'(cmp_out);
			invalid_sel = cmp_invalid;
		end
		OP_FMIN, OP_FMAX:
		begin
			result_sel = mm_result;
			invalid_sel = mm_invalid;
		end
		OP_FCLASS:
		begin
			// mask sits in the low bits
			result_sel = `FPU_HALF_W'(class_mask);
			invalid_sel = 1'b0;
		end
		default:
		begin
			result_sel = '0;
			invalid_sel = 1'b0;
		end
	endcase
end

always_ff @(posedge clk or negedge rst_n)
begin : RSP_STROBES
	if (!rst_n)
	begin
		rsp_valid <= 1'b0;
		req_credit <= 1'b0;
	end
	else
	begin
		rsp_valid <= issue;
		// the popped entry frees one upstream credit
		req_credit <= issue;
	end
end

always_ff @(posedge clk)
begin : RSP_PAYLOAD
	if (issue)
	begin
		rsp_result <= result_sel;
		rsp_invalid <= invalid_sel;
	end
end

endmodule

// File: src/fpu_cmp_unit.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_cmp_unit
(
	input logic clk,
	input logic rst_n,

	input logic req_valid,
	input fpu_types_pkg::fpu_op_t req_op,
	input logic [`FPU_HALF_W - 1 : 0] req_a,
	input logic [`FPU_HALF_W - 1 : 0] req_b,
	output logic req_credit,

	output logic rsp_valid,
	output logic [`FPU_HALF_W - 1 : 0] rsp_result,
	output logic rsp_invalid,
	input logic rsp_credit
);

import fpu_types_pkg::*;

// head of queue operands, shared by all datapath blocks
logic [`FPU_HALF_W - 1 : 0] head_a;
logic [`FPU_HALF_W - 1 : 0] head_b;

fpu_cmp_rm_t cmp_op;
logic take_max;

logic cmp_out;
logic cmp_invalid;
logic [`FPU_HALF_W - 1 : 0] mm_result;
logic mm_invalid;
logic [`FPU_CLASS_W - 1 : 0] class_mask;

fpu_cmp_ctrl i_fpu_cmp_ctrl
(
	.clk(clk),
	.rst_n(rst_n),
	.req_valid(req_valid),
	.req_op(req_op),
	.req_a(req_a),
	.req_b(req_b),
	.req_credit(req_credit),
	.rsp_valid(rsp_valid),
	.rsp_result(rsp_result),
	.rsp_invalid(rsp_invalid),
	.rsp_credit(rsp_credit),
	.head_a(head_a),
	.head_b(head_b),
	.cmp_op(cmp_op),
	.take_max(take_max),
	.cmp_out(cmp_out),
	.cmp_invalid(cmp_invalid),
	.mm_result(mm_result),
	.mm_invalid(mm_invalid),
	.class_mask(class_mask)
);

float_compare i_float_compare
(
	.float1(head_a),
	.float2(head_b),
	.operation(cmp_op),
	.out(cmp_out),
	.invalid(cmp_invalid)
);

fp_minmax i_fp_minmax
(
	.a(head_a),
	.b(head_b),
	.take_max(take_max),
	.result(mm_result),
	.invalid(mm_invalid)
);

// classify looks at the first operand only
fp_classify i_fp_classify
(
	.a(head_a),
	.mask(class_mask)
);

endmodule

// File: test/fpu_cmp_ref.svh
`ifndef FPU_CMP_REF_SVH
`define FPU_CMP_REF_SVH

// expected results built from the half-float rules
// needs fpu_config.svh and an import of fpu_types_pkg before it

// all-ones exponent with a non-zero fraction
function automatic bit half_is_nan(input logic [`FPU_HALF_W - 1 : 0] w);
	return ((w & 16'h7c00) == 16'h7c00) && ((w & 16'h03ff) != 16'h0000);
endfunction

// the fraction msb is the quiet bit
function automatic bit half_is_snan(input logic [`FPU_HALF_W - 1 : 0] w);
	return half_is_nan(w) && ((w & 16'h0200) == 16'h0000);
endfunction

// signed rank for FEQ, FLT and FLE, both zeros rank 0
function automatic int compare_rank(input logic [`FPU_HALF_W - 1 : 0] w);
	int mag;
	mag = int'(w & 16'h7fff);
	return w[15] ? -mag : mag;
endfunction

// same idea, but -0 ranks just below +0
function automatic int minmax_rank(input logic [`FPU_HALF_W - 1 : 0] w);
	int mag;
	mag = int'(w & 16'h7fff);
	return w[15] ? -mag - 1 : mag;
endfunction

// bit position in the RISC-V class mask
function automatic int class_bit(input logic [`FPU_HALF_W - 1 : 0] w);
	bit neg;
	bit exp_ones;
	bit exp_zero;
	bit frac_zero;
	neg = w[15];
	exp_ones = ((w & 16'h7c00) == 16'h7c00);
	exp_zero = ((w & 16'h7c00) == 16'h0000);
	frac_zero = ((w & 16'h03ff) == 16'h0000);
	if (half_is_nan(w))
		return half_is_snan(w) ? 8 : 9;
	if (exp_ones)
		return neg ? 0 : 7;
	if (exp_zero && frac_zero)
		return neg ? 3 : 4;
	if (exp_zero)
		return neg ? 2 : 5;
	return neg ? 1 : 6;
endfunction

// {invalid, result} for one request
function automatic logic [`FPU_HALF_W : 0] expected_response(input fpu_op_t op,
	input logic [`FPU_HALF_W - 1 : 0] a, input logic [`FPU_HALF_W - 1 : 0] b);
	bit any_nan;
	bit any_snan;
	bit flag;
	logic [`FPU_HALF_W - 1 : 0] word;
	any_nan = half_is_nan(a) || half_is_nan(b);
	any_snan = half_is_snan(a) || half_is_snan(b);
	flag = 1'b0;
	word = '0;
	case (op)
		OP_FEQ:
		begin
			flag = any_snan;
			word[0] = !any_nan && (compare_rank(a) == compare_rank(b));
		end
		OP_FLT:
		begin
			flag = any_nan;
			word[0] = !any_nan && (compare_rank(a) < compare_rank(b));
		end
		OP_FLE:
		begin
			flag = any_nan;
			word[0] = !any_nan && (compare_rank(a) <= compare_rank(b));
		end
		OP_FMIN, OP_FMAX:
		begin
			flag = any_snan;
			if (half_is_nan(a) && half_is_nan(b))
				word = `FPU_CANON_NAN;
			else if (half_is_nan(a))
				word = b;
			else if (half_is_nan(b))
				word = a;
			else if (op == OP_FMIN)
				word = (minmax_rank(a) <= minmax_rank(b)) ? a : b;
			else
				word = (minmax_rank(a) >= minmax_rank(b)) ? a : b;
		end
		OP_FCLASS:
			word = 16'h0001 << class_bit(a);
		default:
			word = '0;
	endcase
	return {flag, word};
endfunction

`endif

// File: test/fpu_cmp_tb.sv
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_cmp_tb;

import fpu_types_pkg::*;

`include "fpu_cmp_ref.svh"

localparam int CLK_HALF = 2;
localparam int RESET_CYCLES = 5;
localparam int DRIVE_DELAY = 1;
localparam int TIMEOUT_CYCLES = 2000;
localparam int BURST_COUNT = 400;
localparam int QUIET_CYCLES = 20;
localparam int MIN_LATENCY = 2;
localparam bit [31:0] SEED = 32'hb6f8;
localparam int NUM_SPECIALS = 12;

// zeros, infinities, NaNs of both kinds, subnormals and a few normals
localparam logic [15:0] SPECIALS [NUM_SPECIALS] = '{
	16'h0000, 16'h8000, 16'h7c00, 16'hfc00, 16'h7e00, 16'h7c01,
	16'hfd00, 16'h0001, 16'h83ff, 16'h3c00, 16'hbc00, 16'h7bff
};
localparam fpu_op_t PAIR_OPS [5] = '{OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX};

logic clk;
logic rst_n;
logic req_valid;
fpu_op_t req_op;
logic [`FPU_HALF_W - 1 : 0] req_a;
logic [`FPU_HALF_W - 1 : 0] req_b;
logic req_credit;
logic rsp_valid;
logic [`FPU_HALF_W - 1 : 0] rsp_result;
logic rsp_invalid;
logic rsp_credit;

int errors;
int timeouts;
int cycle_count;
int up_credits;
int rsp_model_credits;
int pending_returns;
int requests_sent;
int responses_seen;
int req_credit_pulses;
int req_sample_edge;
int last_rsp_edge;
bit hold_credits;

// scoreboard, one entry per request in flight
logic [`FPU_HALF_W - 1 : 0] exp_result_q [$];
logic exp_invalid_q [$];
fpu_op_t exp_op_q [$];

fpu_cmp_unit i_fpu_cmp_unit
(
	.clk(clk),
	.rst_n(rst_n),
	.req_valid(req_valid),
	.req_op(req_op),
	.req_a(req_a),
	.req_b(req_b),
	.req_credit(req_credit),
	.rsp_valid(rsp_valid),
	.rsp_result(rsp_result),
	.rsp_invalid(rsp_invalid),
	.rsp_credit(rsp_credit)
);

initial
begin
	clk = 1'b0;
	forever #CLK_HALF clk = ~clk;
end

// strobes stay low while reset is applied
rsp_valid_in_reset: assert property (@(negedge clk) !rst_n |-> !rsp_valid)
else
begin
	errors++;
	$display("error rsp_valid during reset: got %h, expected 0", rsp_valid);
end

req_credit_in_reset: assert property (@(negedge clk) !rst_n |-> !req_credit)
else
begin
	errors++;
	$display("error req_credit during reset: got %h, expected 0", req_credit);
end

// each issue pops one entry, so both strobes go together
credit_with_response: assert property (@(posedge clk) disable iff (!rst_n)
	req_credit == rsp_valid)
else
begin
	errors++;
	$display("error req_credit: got %h, rsp_valid %h", req_credit, rsp_valid);
end

always @(posedge clk)
begin : MONITOR
	logic [`FPU_HALF_W - 1 : 0] exp_result;
	logic exp_invalid;
	fpu_op_t exp_op;
	cycle_count++;
	if (rst_n)
	begin
		if (req_credit)
		begin
			req_credit_pulses++;
			up_credits++;
			assert (up_credits <= `FPU_REQ_DEPTH)
			else
			begin
				errors++;
				$display("error up_credits: got %h, max %h", up_credits, `FPU_REQ_DEPTH);
			end
		end
		if (rsp_valid)
		begin
			responses_seen++;
			last_rsp_edge = cycle_count;
			pending_returns++;
			assert (rsp_model_credits > 0)
			else
			begin
				errors++;
				$display("error rsp_valid: fired with credit count %h", rsp_model_credits);
			end
			rsp_model_credits--;
			assert (exp_result_q.size() != 0)
			else
			begin
				errors++;
				$display("a response arrived with no request outstanding");
			end
			if (exp_result_q.size() != 0)
			begin
				exp_result = exp_result_q.pop_front();
				exp_invalid = exp_invalid_q.pop_front();
				exp_op = exp_op_q.pop_front();
				assert (rsp_result === exp_result)
				else
				begin
					errors++;
					$display("error rsp_result (%s): got %h, expected %h",
						exp_op.name(), rsp_result, exp_result);
				end
				assert (rsp_invalid === exp_invalid)
				else
				begin
					errors++;
					$display("error rsp_invalid (%s): got %h, expected %h",
						exp_op.name(), rsp_invalid, exp_invalid);
				end
				if (exp_op == OP_FCLASS)
				begin
					assert ($onehot(rsp_result[9:0]) && (rsp_result[15:10] == 6'h00))
					else
					begin
						errors++;
						$display("error rsp_result class mask: got %h", rsp_result);
					end
				end
			end
		end
		if (rsp_credit)
			rsp_model_credits++;
	end
end

// downstream hands credits back after a random delay
initial
begin : DOWNSTREAM
	bit allowed;
	int roll;
	rsp_credit = 1'b0;
	forever
	begin
		@(posedge clk);
		allowed = rst_n && !hold_credits;
		roll = $urandom_range(3, 0);
		#DRIVE_DELAY;
		if (allowed && (pending_returns > 0) && (roll == 0))
		begin
			rsp_credit = 1'b1;
			pending_returns--;
		end
		else
			rsp_credit = 1'b0;
	end
end

function automatic logic [`FPU_HALF_W - 1 : 0] random_operand();
	if ($urandom_range(1, 0) == 1)
		return SPECIALS[$urandom_range(NUM_SPECIALS - 1, 0)];
	return 16'($urandom);
endfunction

// called 1 ns after an edge, returns 1 ns after a later edge
task automatic send_request(input fpu_op_t op, input logic [`FPU_HALF_W - 1 : 0] a,
	input logic [`FPU_HALF_W - 1 : 0] b);
	int waited;
	logic [`FPU_HALF_W : 0] expected;
	waited = 0;
	if (timeouts != 0)
		return;
	while (up_credits == 0)
	begin
		@(posedge clk);
		#DRIVE_DELAY;
		waited++;
		if (waited > TIMEOUT_CYCLES)
		begin
			$display("timeout: no request credit came back from the unit");
			timeouts++;
			return;
		end
	end
	expected = expected_response(op, a, b);
	exp_result_q.push_back(expected[`FPU_HALF_W - 1 : 0]);
	exp_invalid_q.push_back(expected[`FPU_HALF_W]);
	exp_op_q.push_back(op);
	req_valid = 1'b1;
	req_op = op;
	req_a = a;
	req_b = b;
	up_credits--;
	requests_sent++;
	req_sample_edge = cycle_count + 1;
	@(posedge clk);
	#DRIVE_DELAY;
	req_valid = 1'b0;
endtask

task automatic wait_for_responses(input int target);
	int waited;
	waited = 0;
	if (timeouts != 0)
		return;
	while (responses_seen < target)
	begin
		@(posedge clk);
		#DRIVE_DELAY;
		waited++;
		if (waited > TIMEOUT_CYCLES)
		begin
			$display("timeout: only %0d of %0d responses arrived", responses_seen, target);
			timeouts++;
			return;
		end
	end
endtask

// all answered and every credit back where it started
task automatic wait_for_drain();
	int waited;
	waited = 0;
	if (timeouts != 0)
		return;
	while ((exp_result_q.size() != 0) || (pending_returns != 0) ||
		(up_credits != `FPU_REQ_DEPTH) || (rsp_model_credits != `FPU_RSP_CREDITS))
	begin
		@(posedge clk);
		#DRIVE_DELAY;
		waited++;
		if (waited > TIMEOUT_CYCLES)
		begin
			$display("timeout: the unit did not drain its requests and credits");
			timeouts++;
			return;
		end
	end
endtask

initial
begin : MAIN
	int i;
	int j;
	int k;
	int base;
	void'($urandom(SEED));
	errors = 0;
	timeouts = 0;
	cycle_count = 0;
	up_credits = `FPU_REQ_DEPTH;
	rsp_model_credits = `FPU_RSP_CREDITS;
	pending_returns = 0;
	requests_sent = 0;
	responses_seen = 0;
	req_credit_pulses = 0;
	req_sample_edge = 0;
	last_rsp_edge = 0;
	hold_credits = 1'b0;
	rst_n = 1'b0;
	req_valid = 1'b0;
	req_op = OP_FEQ;
	req_a = '0;
	req_b = '0;
	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DELAY;
	rst_n = 1'b1;

	// lone request into an empty queue
	send_request(OP_FEQ, 16'h3c00, 16'h3c00);
	wait_for_responses(1);
	assert (last_rsp_edge - req_sample_edge == MIN_LATENCY)
	else
	begin
		errors++;
		$display("error rsp_valid latency: got %h edges, expected %h",
			last_rsp_edge - req_sample_edge, MIN_LATENCY);
	end

	for (k = 0; k < 5; k++)
		for (i = 0; i < NUM_SPECIALS; i++)
			for (j = 0; j < NUM_SPECIALS; j++)
				send_request(PAIR_OPS[k], SPECIALS[i], SPECIALS[j]);
	for (i = 0; i < NUM_SPECIALS; i++)
		send_request(OP_FCLASS, SPECIALS[i], random_operand());

	for (i = 0; i < BURST_COUNT; i++)
		send_request(fpu_op_t'($urandom_range(5, 0)), random_operand(), random_operand());
	wait_for_drain();

	// downstream stops returning credits
	hold_credits = 1'b1;
	base = responses_seen;
	for (i = 0; i < `FPU_REQ_DEPTH; i++)
		send_request(OP_FCLASS, SPECIALS[i], 16'h0000);
	wait_for_responses(base + `FPU_RSP_CREDITS);
	for (k = 0; k < QUIET_CYCLES; k++)
	begin
		@(posedge clk);
		#DRIVE_DELAY;
	end
	assert (responses_seen == base + `FPU_RSP_CREDITS)
	else
	begin
		errors++;
		$display("error responses_seen without credits: got %h, expected %h",
			responses_seen - base, `FPU_RSP_CREDITS);
	end
	hold_credits = 1'b0;
	wait_for_responses(base + `FPU_REQ_DEPTH);
	wait_for_drain();

	assert (req_credit_pulses == requests_sent)
	else
	begin
		errors++;
		$display("error req_credit pulses: got %h, expected %h", req_credit_pulses, requests_sent);
	end
	assert (responses_seen == requests_sent)
	else
	begin
		errors++;
		$display("error rsp_valid count: got %h, expected %h", responses_seen, requests_sent);
	end

	$display("errors: %0d, timeouts: %0d, requests: %0d, responses: %0d",
		errors, timeouts, requests_sent, responses_seen);
	if ((errors == 0) && (timeouts == 0))
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

endmodule

// File: tb.f
+incdir+src
+incdir+test
src/fpu_types_pkg.sv
src/float_compare.sv
src/fp_minmax.sv
src/fp_classify.sv
src/fpu_cmp_ctrl.sv
src/fpu_cmp_unit.sv
test/fpu_cmp_tb.sv

// File: Makefile
TOP = fpu_cmp_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x '>>> PASS' > /dev/null

clean:
	rm -rf obj_dir
